// ==== sources.f ====
logic/icachePkg.sv
logic/lookupIf.sv
logic/refillWriteIf.sv
logic/cacheDataMemory.sv
logic/cacheTagArray.sv
logic/icacheControl.sv
logic/icacheTop.sv
sim/refillMemoryModel.sv
sim/icacheTb.sv

// ==== sim/icacheTb.sv ====
`timescale 1ns/1ps

module icacheTb;

	localparam int indexBits = 6;
	localparam int refillCredits = 2;
	localparam int streamCycles = 600;
	localparam int waitLimit = 500;
	localparam int conflictFetches = 6;

	logic clock;
	logic arstN;
	logic fetchValid;
	icachePkg::addrT fetchAddr;
	logic fetchReady;
	logic respValid;
	icachePkg::addrT respAddr;
	icachePkg::wordT respWord;
	logic refillReqValid;
	icachePkg::addrT refillAddr;
	logic creditReturn;
	logic refillValid;
	icachePkg::lineT refillLine;

	int seed = 32'he01c;
	int valueErrors = 0;
	int protocolErrors = 0;
	int timeouts = 0;

	// Line bases. Pairs share an index so they keep evicting each other
	icachePkg::addrT linePool [8] = '{32'h0000, 32'h0010, 32'h0020, 32'h0400,
		32'h0410, 32'h0800, 32'h03f0, 32'h0bf0};

	// scoreboard of taken fetches with the oldest at the front
	icachePkg::addrT expectQ [$];
	icachePkg::addrT expHead;
	int expCount;
	int takenCount = 0;
	int responseCount = 0;
	int creditCount;
	int conflictRequests = 0;
	// one bit per line number taken from addr[13:4]
	logic [1023:0] requestedLines;
	logic [1023:0] fetchedLines;
	icachePkg::addrT lastRefillAddr;
	logic hitPhase;
	logic conflictPhase;

	icacheTop #(
		.indexBits(indexBits),
		.refillCredits(refillCredits)
	) dut (
		.clock_i(clock),
		.arstN_i(arstN),
		.fetchValid_i(fetchValid),
		.fetchAddr_i(fetchAddr),
		.fetchReady_o(fetchReady),
		.respValid_o(respValid),
		.respAddr_o(respAddr),
		.respWord_o(respWord),
		.refillReqValid_o(refillReqValid),
		.refillAddr_o(refillAddr),
		.refillCreditReturn_i(creditReturn),
		.refillValid_i(refillValid),
		.refillLine_i(refillLine)
	);

	refillMemoryModel #(.randomSeed(32'he01c)) memory (
		.clock_i(clock),
		.arstN_i(arstN),
		.reqValid_i(refillReqValid),
		.reqAddr_i(refillAddr),
		.creditReturn_o(creditReturn),
		.lineValid_o(refillValid),
		.line_o(refillLine)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// scoreboard and credit mirror
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			expectQ.delete();
			expHead <= '0;
			expCount <= 0;
			creditCount <= refillCredits;
			requestedLines <= '0;
			fetchedLines <= '0;
			lastRefillAddr <= '0;
		end
		else
		begin
			// a fetch taken now cannot answer before two edges so the pop comes first
			if (respValid)
			begin
				responseCount++;
				if (expectQ.size() != 0)
					void'(expectQ.pop_front());
			end
			if (fetchValid && fetchReady)
			begin
				expectQ.push_back(fetchAddr);
				takenCount++;
				fetchedLines[fetchAddr[13:4]] <= 1'b1;
			end
			expCount <= expectQ.size();
			expHead <= (expectQ.size() != 0) ? expectQ[0] : '0;
			creditCount <= creditCount - int'(refillReqValid) + int'(creditReturn);
			if (refillReqValid)
			begin
				requestedLines[refillAddr[13:4]] <= 1'b1;
				lastRefillAddr <= refillAddr;
				if (conflictPhase)
					conflictRequests++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// idle outputs and an open fetch port right after reset
	assert property (@(posedge clock)
		$rose(arstN) |-> !respValid && !refillReqValid && fetchReady)
	else
	begin
		protocolErrors++;
		$display("outputs not idle or fetch port closed after reset at %0t", $time);
	end

	assert property (@(posedge clock) disable iff (!arstN) respValid |-> expCount > 0)
	else
	begin
		protocolErrors++;
		$display("response at %0t with no fetch outstanding", $time);
	end

	// in order with nothing lost or doubled
	assert property (@(posedge clock) disable iff (!arstN)
		respValid && expCount > 0 |-> respAddr == expHead)
	else
	begin
		valueErrors++;
		$display("error %0t respAddr_o got %h expected %h", $time,
			$sampled(respAddr), $sampled(expHead));
	end

	// word at a word aligned address A holds ~A
	assert property (@(posedge clock) disable iff (!arstN)
		respValid && expCount > 0 |-> respWord == ~(expHead & 32'hffff_fffc))
	else
	begin
		valueErrors++;
		$display("error %0t respWord_o got %h expected %h", $time,
			$sampled(respWord), ~($sampled(expHead) & 32'hffff_fffc));
	end

	// a cold line can never hit
	assert property (@(posedge clock) disable iff (!arstN)
		respValid |-> requestedLines[respAddr[13:4]])
	else
	begin
		protocolErrors++;
		$display("response at %0t for a line that was never requested", $time);
	end

	// the missed fetch is always the oldest one still waiting
	assert property (@(posedge clock) disable iff (!arstN)
		refillReqValid |-> refillAddr == (expHead & 32'hffff_fff0))
	else
	begin
		valueErrors++;
		$display("error %0t refillAddr_o got %h expected %h", $time,
			$sampled(refillAddr), $sampled(expHead) & 32'hffff_fff0);
	end

	assert property (@(posedge clock) disable iff (!arstN) refillReqValid |-> creditCount > 0)
	else
	begin
		protocolErrors++;
		$display("refill request at %0t with no credit left", $time);
	end

	assert property (@(posedge clock) disable iff (!arstN)
		hitPhase && fetchValid && fetchReady
		|-> ##2 respValid && respAddr == $past(fetchAddr, 2))
	else
	begin
		protocolErrors++;
		$display("hit taken two cycles before %0t did not respond on time", $time);
	end

	assert property (@(posedge clock) disable iff (!arstN) hitPhase |-> !refillReqValid)
	else
	begin
		protocolErrors++;
		$display("refill request at %0t for a line that should hit", $time);
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic icachePkg::addrT pickAddr();
		icachePkg::addrT base;
		icachePkg::addrT wordSel;
		base = linePool[$random(seed) & 7];
		wordSel = ($random(seed) & 3) << 2;
		return base | wordSel;
	endfunction

	// drives one fetch and returns on the edge that takes it
	task automatic sendFetch(input icachePkg::addrT addr);
		int waited;
		waited = 0;
		fetchValid <= 1'b1;
		fetchAddr <= addr;
		@(posedge clock);
		while (!fetchReady && waited < waitLimit)
		begin
			@(posedge clock);
			waited++;
		end
		if (!fetchReady)
		begin
			timeouts++;
			$display("timeout: fetch %h was never accepted", addr);
		end
	endtask

	// until every taken fetch has its response and the port is open again
	task automatic waitDrain();
		int waited;
		waited = 0;
		@(posedge clock);
		while ((expCount != 0 || !fetchReady) && waited < waitLimit)
		begin
			@(posedge clock);
			waited++;
		end
		if (expCount != 0 || !fetchReady)
		begin
			timeouts++;
			$display("timeout: fetches still outstanding after %0d cycles", waitLimit);
		end
	endtask

	initial
	begin
		int cycle;
		logic stopped;
		arstN = 1'b0;
		fetchValid = 1'b0;
		fetchAddr = '0;
		hitPhase = 1'b0;
		conflictPhase = 1'b0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);

		// random stream where a fetch not yet taken stays on the bus
		cycle = 0;
		stopped = 1'b0;
		while (!stopped && cycle < streamCycles + waitLimit)
		begin
			@(posedge clock);
			cycle++;
			if (!(fetchValid && !fetchReady))
			begin
				if (cycle > streamCycles)
				begin
					fetchValid <= 1'b0;
					stopped = 1'b1;
				end
				else
				begin
					fetchValid <= ($random(seed) & 3) != 0;
					fetchAddr <= pickAddr();
				end
			end
		end
		if (!stopped)
		begin
			timeouts++;
			$display("timeout: last random fetch was never accepted");
		end
		if (timeouts == 0)
			waitDrain();

		// last refilled line is still resident for one hit and then four in a row
		if (timeouts == 0)
		begin
			hitPhase <= 1'b1;
			sendFetch(lastRefillAddr);
			fetchValid <= 1'b0;
			waitDrain();
			for (cycle = 0; cycle < 4; cycle++)
				sendFetch(lastRefillAddr | (32'(cycle) << 2));
			fetchValid <= 1'b0;
			waitDrain();
			hitPhase <= 1'b0;
		end

		// same index with different tags so each one evicts the other
		if (timeouts == 0)
		begin
			conflictPhase <= 1'b1;
			for (cycle = 0; cycle < conflictFetches; cycle++)
			begin
				sendFetch((cycle % 2 == 0) ? 32'h1000 : 32'h1404);
				fetchValid <= 1'b0;
				waitDrain();
			end
			conflictPhase <= 1'b0;
		end

		@(posedge clock);
		assert (conflictRequests == conflictFetches)
		else
		begin
			protocolErrors++;
			$display("%0d refill requests for %0d conflicting fetches",
				conflictRequests, conflictFetches);
		end
		assert (responseCount == takenCount)
		else
		begin
			protocolErrors++;
			$display("%0d responses for %0d taken fetches", responseCount, takenCount);
		end
		assert (expCount == 0 && fetchReady)
		else
		begin
			protocolErrors++;
			$display("fetches still queued or fetch port closed at the end");
		end
		assert ((fetchedLines & ~requestedLines) == '0)
		else
		begin
			protocolErrors++;
			$display("a fetched line never raised a refill request");
		end

		$display("errors: %0d value, %0d protocol, %0d timeout",
			valueErrors, protocolErrors, timeouts);
		if (valueErrors + protocolErrors + timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim/refillMemoryModel.sv ====
`timescale 1ns/1ps

// next memory level behind the cache, one line per request
module refillMemoryModel #(
	parameter int randomSeed = 32'he01c
) (
	input logic clock_i,
	input logic arstN_i,
	input logic reqValid_i,
	input icachePkg::addrT reqAddr_i,
	output logic creditReturn_o,
	output logic lineValid_o,
	output icachePkg::lineT line_o
);

	int seed = randomSeed;
	int cycle;
	// pending requests in arrival order, each with the cycle it is due
	icachePkg::addrT addrQ [$];
	int dueQ [$];
	// credits go back some time after their data
	int creditDueQ [$];

	function automatic int randomBelow(input int span);
		return ($random(seed) & 32'h7fff_ffff) % span;
	endfunction

	// word at address A is ~A, word 0 in the low bits
	function automatic icachePkg::lineT lineFor(input icachePkg::addrT lineAddr);
		icachePkg::lineT line;
		int w;
		for (w = 0; w < icachePkg::wordsPerLine; w++)
			line[w * 32 +: 32] = ~(lineAddr + 32'(w * 4));
		return line;
	endfunction

	always @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			cycle = 0;
			addrQ.delete();
			dueQ.delete();
			creditDueQ.delete();
			creditReturn_o <= 1'b0;
			lineValid_o <= 1'b0;
			line_o <= '0;
		end
		else
		begin
			cycle = cycle + 1;
			lineValid_o <= 1'b0;
			creditReturn_o <= 1'b0;
			// answer 1 to 8 cycles later
			if (reqValid_i)
			begin
				addrQ.push_back(reqAddr_i & 32'hffff_fff0);
				dueQ.push_back(cycle + 1 + randomBelow(8));
			end
			if (dueQ.size() != 0 && dueQ[0] <= cycle)
			begin
				lineValid_o <= 1'b1;
				line_o <= lineFor(addrQ.pop_front());
				void'(dueQ.pop_front());
				// 0 to 6 cycles late, so the cache can run out
				creditDueQ.push_back(cycle + randomBelow(7));
			end
			if (creditDueQ.size() != 0 && creditDueQ[0] <= cycle)
			begin
				creditReturn_o <= 1'b1;
				void'(creditDueQ.pop_front());
			end
		end
	end

endmodule

// ==== logic/icacheTop.sv ====
`timescale 1ns/1ps

module icacheTop #(
	parameter int indexBits = 6,
	parameter int refillCredits = 2
) (
	input logic clock_i,
	input logic arstN_i,
	// fetch requests
	input logic fetchValid_i,
	input icachePkg::addrT fetchAddr_i,
	output logic fetchReady_o,
	// in-order responses, always taken by the fetch unit
	output logic respValid_o,
	output icachePkg::addrT respAddr_o,
	output icachePkg::wordT respWord_o,
	// next level, credit based
	output logic refillReqValid_o,
	output icachePkg::addrT refillAddr_o,
	input logic refillCreditReturn_i,
	input logic refillValid_i,
	input icachePkg::lineT refillLine_i
);

	//////////////////////////////////////////////////////////////////////
	// array results back to control
	//////////////////////////////////////////////////////////////////////

	logic hitValid;
	logic hit;
	icachePkg::addrT hitAddr;
	icachePkg::wordT word;

	lookupIf #(.indexBits(indexBits)) lookupBus ();
	refillWriteIf #(.indexBits(indexBits)) writeBus ();

	icacheControl #(
		.indexBits(indexBits),
		.refillCredits(refillCredits)
	) control (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.fetchValid_i(fetchValid_i),
		.fetchAddr_i(fetchAddr_i),
		.fetchReady_o(fetchReady_o),
		.lookup(lookupBus.issuer),
		.write(writeBus.writer),
		.hitValid_i(hitValid),
		.hit_i(hit),
		.hitAddr_i(hitAddr),
		.word_i(word),
		.respValid_o(respValid_o),
		.respAddr_o(respAddr_o),
		.respWord_o(respWord_o),
		.refillReqValid_o(refillReqValid_o),
		.refillAddr_o(refillAddr_o),
		.refillCreditReturn_i(refillCreditReturn_i),
		.refillValid_i(refillValid_i),
		.refillLine_i(refillLine_i)
	);

	// tags and valid bits, in step with the data memory
	cacheTagArray #(.indexBits(indexBits)) tagArray (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.lookup(lookupBus.reader),
		.write(writeBus.store),
		.hitValid_o(hitValid),
		.hit_o(hit),
		.hitAddr_o(hitAddr)
	);

	cacheDataMemory #(.indexBits(indexBits)) dataMemory (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.lookup(lookupBus.reader),
		.write(writeBus.store),
		.word_o(word)
	);

endmodule

// ==== logic/icacheControl.sv ====
`timescale 1ns/1ps

module icacheControl #(
	parameter int indexBits = 6,
	parameter int refillCredits = 2
) (
	input logic clock_i,
	input logic arstN_i,
	input logic fetchValid_i,
	input icachePkg::addrT fetchAddr_i,
	output logic fetchReady_o,
	lookupIf.issuer lookup,
	refillWriteIf.writer write,
	input logic hitValid_i,
	input logic hit_i,
	input icachePkg::addrT hitAddr_i,
	input icachePkg::wordT word_i,
	output logic respValid_o,
	output icachePkg::addrT respAddr_o,
	output icachePkg::wordT respWord_o,
	output logic refillReqValid_o,
	output icachePkg::addrT refillAddr_o,
	input logic refillCreditReturn_i,
	input logic refillValid_i,
	input icachePkg::lineT refillLine_i
);

	localparam int offBits = icachePkg::lineOffsetBits;
	localparam int tagBits = 32 - offBits - indexBits;
	localparam int creditBits = $clog2(refillCredits + 1);

	typedef enum logic [2:0] {running, requestRefill, awaitRefill, writeLine, replay} stateT;

	stateT state;
	stateT stateNext;
	logic [creditBits-1:0] creditCount;
	logic missNow;
	icachePkg::addrT issueAddr;
	// lookup issued on the previous edge, still one stage away from its result
	logic issue1Valid;
	icachePkg::addrT issue1Addr;
	// missed fetch first, then the younger ones in issue order
	icachePkg::addrT replayQ [3];
	logic [1:0] replayCount;
	icachePkg::lineT lineBuf;

	//////////////////////////////////////////////////////////////////////
	// fetch side
	//////////////////////////////////////////////////////////////////////

	assign fetchReady_o = (state == running);
	// replay takes the lookup port over from the fetch unit
	assign lookup.valid = (state == running && fetchValid_i) || state == replay;
	assign issueAddr = (state == replay) ? replayQ[0] : fetchAddr_i;
	assign lookup.tag = issueAddr[31 -: tagBits];
	assign lookup.index = issueAddr[offBits +: indexBits];
	assign lookup.offset = issueAddr[offBits-1:0];

	// results outside running and replay belong to cancelled lookups
	assign missNow = (state == running) && hitValid_i && !hit_i;
	assign respValid_o = (state == running || state == replay) && hitValid_i && hit_i;
	assign respAddr_o = hitAddr_i;
	assign respWord_o = word_i;

	//////////////////////////////////////////////////////////////////////
	// refill side
	//////////////////////////////////////////////////////////////////////

	// line aligned address of the missed fetch
	assign refillReqValid_o = (state == requestRefill) && (creditCount != '0);
	assign refillAddr_o = {replayQ[0][31:offBits], {offBits{1'b0}}};

	assign write.enable = (state == writeLine);
	assign write.index = replayQ[0][offBits +: indexBits];
	assign write.tag = replayQ[0][31 -: tagBits];
	assign write.line = lineBuf;

	always_comb
	begin
		stateNext = state;
		case (state)
			running: if (missNow) stateNext = requestRefill;
			// hold here until a credit is free
			requestRefill: if (creditCount != '0) stateNext = awaitRefill;
			awaitRefill: if (refillValid_i) stateNext = writeLine;
			writeLine: stateNext = replay;
			replay: if (replayCount == 2'd1) stateNext = running;
			default: stateNext = running;
		endcase
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			state <= running;
			creditCount <= creditBits'(refillCredits);
			issue1Valid <= 1'b0;
			replayCount <= 2'd0;
		end
		else
		begin
			state <= stateNext;
			creditCount <= creditCount - creditBits'(refillReqValid_o)
				+ creditBits'(refillCreditReturn_i);
			issue1Valid <= lookup.valid;
			if (missNow)
				replayCount <= 2'd1 + 2'(issue1Valid) + 2'(lookup.valid);
			else if (state == replay)
				replayCount <= replayCount - 2'd1;
		end
	end

	// queue and line buffer, data only
	always_ff @(posedge clock_i)
	begin
		issue1Addr <= issueAddr;
		if (missNow)
		begin
			replayQ[0] <= hitAddr_i;
			// pack the in-flight lookups behind the missed one, oldest first
			if (issue1Valid)
			begin
				replayQ[1] <= issue1Addr;
				replayQ[2] <= issueAddr;
			end
			else
				replayQ[1] <= issueAddr;
		end
		else if (state == replay)
		begin
			replayQ[0] <= replayQ[1];
			replayQ[1] <= replayQ[2];
		end
		if (state == awaitRefill && refillValid_i)
			lineBuf <= refillLine_i;
	end

	assert property (@(posedge clock_i) disable iff (!arstN_i) creditCount <= refillCredits);
	assert property (@(posedge clock_i) disable iff (!arstN_i)
		refillReqValid_o |-> creditCount != '0);
	// at most one miss outstanding, so data only comes while waiting for it
	assert property (@(posedge clock_i) disable iff (!arstN_i)
		refillValid_i |-> state == awaitRefill);
	// the first replayed fetch targets the line just written and must hit
	assert property (@(posedge clock_i) disable iff (!arstN_i)
		(state == replay && hitValid_i) |-> hit_i);

endmodule

// ==== logic/cacheTagArray.sv ====
`timescale 1ns/1ps

module cacheTagArray #(
	parameter int indexBits = 6
) (
	input logic clock_i,
	input logic arstN_i,
	lookupIf.reader lookup,
	refillWriteIf.store write,
	output logic hitValid_o,
	output logic hit_o,
	output icachePkg::addrT hitAddr_o
);

	localparam int numLines = 2 ** indexBits;
	localparam int tagBits = 32 - icachePkg::lineOffsetBits - indexBits;

	//////////////////////////////////////////////////////////////////////
	// tag and valid storage
	//////////////////////////////////////////////////////////////////////

	logic [tagBits-1:0] tags [numLines];
	// valid bits are the only part that must come up known
	logic [numLines-1:0] lineValid;

	always_ff @(posedge clock_i)
	begin
		if (write.enable)
		begin
			tags[write.index] <= write.tag;
		end
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			lineValid <= '0;
		else if (write.enable)
			lineValid[write.index] <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// lookup pipeline
	//////////////////////////////////////////////////////////////////////

	// stage 1: stored tag read, request fields carried along
	logic stageValid;
	logic storedValid;
	logic [tagBits-1:0] storedTag;
	logic [tagBits-1:0] tagStage;
	logic [indexBits-1:0] indexStage;
	logic [icachePkg::lineOffsetBits-1:0] offsetStage;

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			stageValid <= 1'b0;
			hitValid_o <= 1'b0;
		end
		else
		begin
			stageValid <= lookup.valid;
			hitValid_o <= stageValid;
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (lookup.valid)
		begin
			storedTag <= tags[lookup.index];
			storedValid <= lineValid[lookup.index];
			tagStage <= lookup.tag;
			indexStage <= lookup.index;
			offsetStage <= lookup.offset;
		end
		// stage 2: compare, and hand the fetch address back to control
		hit_o <= storedValid && (storedTag == tagStage);
		hitAddr_o <= {tagStage, indexStage, offsetStage};
	end

	// same port sharing rule as the data memory
	assert property (@(posedge clock_i) disable iff (!arstN_i)
		!(lookup.valid && write.enable));

endmodule

// ==== logic/cacheDataMemory.sv ====
`timescale 1ns/1ps

module cacheDataMemory #(
	parameter int indexBits = 6
) (
	input logic clock_i,
	input logic arstN_i,
	lookupIf.reader lookup,
	refillWriteIf.store write,
	output icachePkg::wordT word_o
);

	localparam int numLines = 2 ** indexBits;
	// bits of the offset that pick a word inside the line
	localparam int wordSelBits = $clog2(icachePkg::wordsPerLine);
	localparam int wordBits = $bits(icachePkg::wordT);

	//////////////////////////////////////////////////////////////////////
	// line store
	//////////////////////////////////////////////////////////////////////

	icachePkg::lineT lines [numLines];

	// whole line write, visible to a lookup on the next edge
	always_ff @(posedge clock_i)
	begin
		if (write.enable)
		begin
			lines[write.index] <= write.line;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read pipeline
	//////////////////////////////////////////////////////////////////////

	// stage 1: registered line read plus the word select it needs
	icachePkg::lineT lineStage;
	logic [wordSelBits-1:0] wordSelStage;

	always_ff @(posedge clock_i)
	begin
		if (lookup.valid)
		begin
			lineStage <= lines[lookup.index];
			// drop the byte bits, keep the word number
			wordSelStage <= lookup.offset[icachePkg::lineOffsetBits-1 -: wordSelBits];
		end
	end

	// stage 2: word select, lines up with hit from the tag array
	always_ff @(posedge clock_i)
	begin
		word_o <= lineStage[wordSelStage * wordBits +: wordBits];
	end

	// single port: control must never overlap a lookup with a refill write
	assert property (@(posedge clock_i) disable iff (!arstN_i)
		!(lookup.valid && write.enable));

endmodule

// ==== logic/refillWriteIf.sv ====
`timescale 1ns/1ps

// one line write, fanned out from control to the tag array and the data memory
interface refillWriteIf #(
	parameter int indexBits = 6
);

	localparam int tagBits = 32 - icachePkg::lineOffsetBits - indexBits;

	// one write per cycle with enable high
	logic enable;
	logic [indexBits-1:0] index;
	logic [tagBits-1:0] tag;
	// full refilled line, only the data memory stores it
	icachePkg::lineT line;

	// control side
	modport writer (output enable, index, tag, line);

	// array side
	modport store (input enable, index, tag, line);

endinterface

// ==== logic/lookupIf.sv ====
`timescale 1ns/1ps

// one lookup, fanned out from control to the tag array and the data memory
interface lookupIf #(
	parameter int indexBits = 6
);

	// whatever is left of the address above index and offset
	localparam int tagBits = 32 - icachePkg::lineOffsetBits - indexBits;

	// a new lookup starts in each cycle with valid high
	logic valid;
	logic [tagBits-1:0] tag;
	logic [indexBits-1:0] index;
	logic [icachePkg::lineOffsetBits-1:0] offset;

	// control side
	modport issuer (output valid, tag, index, offset);

	// array side
	modport reader (input valid, tag, index, offset);

endinterface

// ==== logic/icachePkg.sv ====
package icachePkg;

	//////////////////////////////////////////////////////////////////////
	// fetch side types
	//////////////////////////////////////////////////////////////////////

	// byte address as the fetch unit issues it
	typedef logic [31:0] addrT;

	// one instruction word
	typedef logic [31:0] wordT;

	//////////////////////////////////////////////////////////////////////
	// line geometry
	//////////////////////////////////////////////////////////////////////

	// byte offset inside one line, 16 bytes per line
	localparam int lineOffsetBits = 4;

	// words held by one line
	localparam int wordsPerLine = 4;

	// whole line, word 0 sits in the low bits
	typedef logic [127:0] lineT;

endpackage
